// ==== matAccPkg.sv ====
package matAccPkg;

    // Width of one operand as seen by a multiplier
    localparam int DataWidth = 8;

    // Products and every sum built from them use twice the operand width
    localparam int ProductWidth = 2 * DataWidth;

    // One input port's operands
    typedef struct packed {
        logic [DataWidth-1:0] multiplier;
        logic [DataWidth-1:0] multiplicand;
    } operandPair_t;

    // Unsigned product word
    // Also used for crossbar lanes, lane sums and the final total
    // These all wrap modulo 2**ProductWidth
    typedef logic [ProductWidth-1:0] product_t;

    // Reducer sweep phases
    typedef enum logic [1:0] {
        Idle,
        Sweep,
        Done
    } reduceState_t;

endpackage

// ==== seqMultiplier.sv ====
module seqMultiplier (
    input  logic                    Clk,
    input  logic                    Rst,
    input  logic                    start,
    input  matAccPkg::operandPair_t pair,
    output matAccPkg::product_t     product,
    output logic                    ready
);
    import matAccPkg::*;

    // One bit of the multiplier per cycle
    localparam int CountWidth = (DataWidth > 1) ? $clog2(DataWidth) : 1;
    localparam logic [CountWidth-1:0] LastBit = CountWidth'(DataWidth - 1);

    logic [CountWidth-1:0] bitCount;
    logic [DataWidth-1:0]  multiplierShift;
    product_t              multiplicandShift;
    product_t              partialSum;
    product_t              nextPartial;
    logic                  accept;

    assign accept = start && ready;

    // Add the shifted multiplicand when the current multiplier bit is set
    always_comb begin
        nextPartial = partialSum;
        if (multiplierShift[0]) begin
            nextPartial = partialSum + multiplicandShift;
        end
    end

    // Busy flag, bit counter and the visible result
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            ready    <= 1'b1;
            bitCount <= '0;
            product  <= '0;
        end else if (accept) begin
            ready    <= 1'b0;
            bitCount <= '0;
        end else if (!ready) begin
            bitCount <= bitCount + 1'b1;
            // Last partial product goes straight into the result
            if (bitCount == LastBit) begin
                ready   <= 1'b1;
                product <= nextPartial;
            end
        end
    end

    // Shift registers for the operands and the running partial sum
    always_ff @(posedge Clk) begin
        if (accept) begin
            multiplierShift   <= pair.multiplier;
            multiplicandShift <= {{DataWidth{1'b0}}, pair.multiplicand};
            partialSum        <= '0;
        end else if (!ready) begin
            multiplierShift   <= multiplierShift >> 1;
            multiplicandShift <= multiplicandShift << 1;
            partialSum        <= nextPartial;
        end
    end

    // A new pair may only arrive once the previous product is out
    assert property (@(posedge Clk) disable iff (Rst) start |-> ready)
        else $error("seqMultiplier: start while busy");

endmodule

// ==== productCrossbar.sv ====
module productCrossbar #(
    parameter int  InPortCount  = 4,
    parameter int  OutPortCount = 4,
    localparam int SelWidth     = (InPortCount > 1) ? $clog2(InPortCount) : 1
) (
    input  logic                                   Clk,
    input  logic                                   Rst,
    input  matAccPkg::product_t [InPortCount-1:0]  products,
    input  logic [OutPortCount-1:0][SelWidth-1:0]  addressSelect,
    input  logic                                   direct,
    output matAccPkg::product_t [OutPortCount-1:0] routed
);
    import matAccPkg::*;

    product_t [OutPortCount-1:0] nextRouted;

    genvar m;
    generate
        for (m = 0; m < OutPortCount; m++) begin : gOut
            product_t directLane;

            // Outputs without a same-index input read zero in direct mode
            if (m < InPortCount) begin : gDirect
                assign directLane = products[m];
            end else begin : gNoDirect
                assign directLane = '0;
            end

            assign nextRouted[m] = direct ? directLane : products[addressSelect[m]];

            // Select indices past the last input have no source lane
            assert property (@(posedge Clk) disable iff (Rst)
                !direct |-> (addressSelect[m] < InPortCount))
                else $error("productCrossbar: select %0d out of range on output %0d",
                            addressSelect[m], m);
        end
    endgenerate

    // All lanes registered together
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            routed <= '0;
        end else begin
            routed <= nextRouted;
        end
    end

endmodule

// ==== productAccumulator.sv ====
module productAccumulator (
    input  logic                Clk,
    input  logic                Rst,
    input  matAccPkg::product_t addend,
    input  logic                add,
    output matAccPkg::product_t sum
);

    // Running total that wraps at the product width
    // Holds whenever add is low
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            sum <= '0;
        end else if (add) begin
            sum <= sum + addend;
        end
    end

endmodule

// ==== finalReducer.sv ====
module finalReducer #(
    parameter int  OutPortCount = 4,
    localparam int PtrWidth     = $clog2(OutPortCount + 1)
) (
    input  logic                                   Clk,
    input  logic                                   Rst,
    input  matAccPkg::product_t [OutPortCount-1:0] sums,
    input  logic                                   finalAdd,
    output matAccPkg::product_t                    finalAccumulate,
    output logic                                   finalReady
);
    import matAccPkg::*;

    // Pointer value reached once every lane has been added
    localparam logic [PtrWidth-1:0] EndPtr = PtrWidth'(OutPortCount);

    reduceState_t        state;
    logic [PtrWidth-1:0] pointer;
    product_t            addend;
    logic                sweepAdd;

    // Lane picked by the pointer and zero once the sweep has passed the end
    always_comb begin
        addend = '0;
        for (int i = 0; i < OutPortCount; i++) begin
            if (pointer == PtrWidth'(i)) begin
                addend = sums[i];
            end
        end
    end

    // sums[0] goes in on the finalAdd edge itself
    assign sweepAdd = ((state == Idle) && finalAdd) ||
                      ((state == Sweep) && (pointer != EndPtr));

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            state   <= Idle;
            pointer <= '0;
        end else begin
            case (state)
                Idle: begin
                    if (finalAdd) begin
                        state   <= Sweep;
                        pointer <= pointer + 1'b1;
                    end
                end
                Sweep: begin
                    if (pointer == EndPtr) begin
                        state <= Done;
                    end else begin
                        pointer <= pointer + 1'b1;
                    end
                end
                // Done holds until reset
                default: state <= Done;
            endcase
        end
    end

    assign finalReady = (state == Done);

    productAccumulator uFinalAcc (
        .Clk    (Clk),
        .Rst    (Rst),
        .addend (addend),
        .add    (sweepAdd),
        .sum    (finalAccumulate)
    );

    // Extra finalAdd pulses are dropped, so the total cannot change after Done
    assert property (@(posedge Clk) disable iff (Rst) finalAdd |-> (state == Idle))
        else $warning("finalReducer: finalAdd ignored outside Idle");

endmodule

// ==== matrixAccelerator.sv ====
module matrixAccelerator #(
    parameter int  InPortCount  = 4,
    parameter int  OutPortCount = 4,
    localparam int SelWidth     = (InPortCount > 1) ? $clog2(InPortCount) : 1
) (
    input  logic                                      Clk,
    input  logic                                      Rst,
    input  matAccPkg::operandPair_t [InPortCount-1:0] operands,
    input  logic [InPortCount-1:0]                    mStart,
    input  logic [OutPortCount-1:0][SelWidth-1:0]     addressSelect,
    input  logic                                      direct,
    input  logic [OutPortCount-1:0]                   add,
    input  logic                                      finalAdd,
    output logic [InPortCount-1:0]                    mReady,
    output matAccPkg::product_t                       finalAccumulate,
    output logic                                      finalReady
);
    import matAccPkg::*;

    // Multiplier results into the crossbar
    product_t [InPortCount-1:0]  products;
    // Crossbar lanes into the accumulators
    product_t [OutPortCount-1:0] routed;
    // Per-lane totals into the reducer
    product_t [OutPortCount-1:0] sums;

    genvar n;
    generate
        for (n = 0; n < InPortCount; n++) begin : gMult
            seqMultiplier uMult (
                .Clk     (Clk),
                .Rst     (Rst),
                .start   (mStart[n]),
                .pair    (operands[n]),
                .product (products[n]),
                .ready   (mReady[n])
            );
        end
    endgenerate

    productCrossbar #(
        .InPortCount  (InPortCount),
        .OutPortCount (OutPortCount)
    ) uCrossbar (
        .Clk           (Clk),
        .Rst           (Rst),
        .products      (products),
        .addressSelect (addressSelect),
        .direct        (direct),
        .routed        (routed)
    );

    genvar m;
    generate
        for (m = 0; m < OutPortCount; m++) begin : gAcc
            productAccumulator uAcc (
                .Clk    (Clk),
                .Rst    (Rst),
                .addend (routed[m]),
                .add    (add[m]),
                .sum    (sums[m])
            );
        end
    endgenerate

    finalReducer #(
        .OutPortCount (OutPortCount)
    ) uReducer (
        .Clk             (Clk),
        .Rst             (Rst),
        .sums            (sums),
        .finalAdd        (finalAdd),
        .finalAccumulate (finalAccumulate),
        .finalReady      (finalReady)
    );

endmodule

// ==== tbMatrixAccelerator.sv ====
module tbMatrixAccelerator;
    import matAccPkg::*;

    localparam int InPorts      = 4;
    localparam int OutPorts     = 4;
    localparam int SelWidth     = 2;
    localparam int ReadyTimeout = 40;

    logic                                 Clk;
    logic                                 Rst;
    operandPair_t [InPorts-1:0]           operands;
    logic [InPorts-1:0]                   mStart;
    logic [OutPorts-1:0][SelWidth-1:0]    addressSelect;
    logic                                 direct;
    logic [OutPorts-1:0]                  add;
    logic                                 finalAdd;
    logic [InPorts-1:0]                   mReady;
    product_t                             finalAccumulate;
    logic                                 finalReady;

    int           seed;
    int           errorCount;
    int           timeoutCount;
    product_t     prodExp [InPorts];
    product_t     expTotal;
    int           busyLeft [InPorts];
    logic [InPorts-1:0] expReady;
    reduceState_t modelState;
    int           sweepLeft;

    matrixAccelerator #(
        .InPortCount  (InPorts),
        .OutPortCount (OutPorts)
    ) UUT (
        .Clk             (Clk),
        .Rst             (Rst),
        .operands        (operands),
        .mStart          (mStart),
        .addressSelect   (addressSelect),
        .direct          (direct),
        .add             (add),
        .finalAdd        (finalAdd),
        .mReady          (mReady),
        .finalAccumulate (finalAccumulate),
        .finalReady      (finalReady)
    );

    always #5 Clk = ~Clk;

    // Multiplier busy window of DataWidth cycles per accepted start
    always @(posedge Clk or posedge Rst) begin
        for (int n = 0; n < InPorts; n++) begin
            if (Rst) begin
                busyLeft[n] <= 0;
            end else if (mStart[n] && busyLeft[n] == 0) begin
                busyLeft[n] <= DataWidth;
            end else if (busyLeft[n] > 0) begin
                busyLeft[n] <= busyLeft[n] - 1;
            end
        end
    end

    always_comb begin
        for (int n = 0; n < InPorts; n++) begin
            expReady[n] = (busyLeft[n] == 0);
        end
    end

    // Reducer phases where Done is reached OutPortCount edges after the finalAdd edge
    always @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            modelState <= Idle;
            sweepLeft  <= 0;
        end else begin
            case (modelState)
                Idle: begin
                    if (finalAdd) begin
                        modelState <= Sweep;
                        sweepLeft  <= OutPorts;
                    end
                end
                Sweep: begin
                    if (sweepLeft == 1) begin
                        modelState <= Done;
                    end else begin
                        sweepLeft <= sweepLeft - 1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // Reset values checked on the first edge after Rst drops
    assert property (@(posedge Clk) $fell(Rst) |->
        (mReady == {InPorts{1'b1}} && !finalReady && finalAccumulate == '0))
        else begin
            errorCount = errorCount + 1;
            $display("Error at %0t: wrong outputs after reset", $time);
        end

    assert property (@(posedge Clk) disable iff (Rst) mReady == expReady)
        else begin
            errorCount = errorCount + 1;
            $display("Error at %0t: mReady is %b, expected %b", $time, mReady, expReady);
        end

    assert property (@(posedge Clk) disable iff (Rst) finalReady == (modelState == Done))
        else begin
            errorCount = errorCount + 1;
            $display("Error at %0t: finalReady is %b, reducer expected in %s",
                     $time, finalReady, modelState.name());
        end

    assert property (@(posedge Clk) disable iff (Rst) $rose(finalReady) |->
        finalAccumulate == expTotal)
        else begin
            errorCount = errorCount + 1;
            $display("Error at %0t: total is %h, expected %h", $time, finalAccumulate, expTotal);
        end

    // Total stays frozen once Done even with an extra finalAdd
    assert property (@(posedge Clk) disable iff (Rst) (finalReady && $past(finalReady)) |->
        finalAccumulate == $past(finalAccumulate))
        else begin
            errorCount = errorCount + 1;
            $display("Error at %0t: total changed after finalReady", $time);
        end

    task automatic applyReset();
        @(negedge Clk);
        Rst           = 1'b1;
        mStart        = '0;
        add           = '0;
        finalAdd      = 1'b0;
        direct        = 1'b0;
        addressSelect = '0;
        repeat (4) @(negedge Clk);
        Rst = 1'b0;
    endtask

    task automatic waitAllReady();
        int cycles;
        cycles = 0;
        while (mReady != {InPorts{1'b1}} && cycles < ReadyTimeout) begin
            @(negedge Clk);
            cycles++;
        end
        if (mReady != {InPorts{1'b1}}) begin
            timeoutCount++;
            $display("Timeout: multipliers did not return to ready");
        end
    endtask

    task automatic waitFinalReady();
        int cycles;
        cycles = 0;
        while (!finalReady && cycles < ReadyTimeout) begin
            @(negedge Clk);
            cycles++;
        end
        if (!finalReady) begin
            timeoutCount++;
            $display("Timeout: reducer never raised finalReady");
        end
    endtask

    // Random pairs with one start per cycle so busy windows overlap
    task automatic startMultipliers();
        logic [31:0] rnd;
        for (int n = 0; n < InPorts; n++) begin
            rnd = $random(seed);
            operands[n].multiplier   = rnd[7:0];
            operands[n].multiplicand = rnd[15:8];
            prodExp[n] = product_t'(rnd[7:0]) * product_t'(rnd[15:8]);
        end
        for (int n = 0; n < InPorts; n++) begin
            @(negedge Clk);
            mStart = InPorts'(1) << n;
        end
        @(negedge Clk);
        mStart = '0;
        waitAllReady();
    endtask

    task automatic routeAndStrobe(input logic isDirect,
                                  input logic [OutPorts-1:0][SelWidth-1:0] sel,
                                  input logic [OutPorts-1:0][2:0] counts);
        int src;
        expTotal = '0;
        for (int m = 0; m < OutPorts; m++) begin
            src = isDirect ? m : int'(sel[m]);
            for (int k = 0; k < int'(counts[m]); k++) begin
                expTotal = expTotal + prodExp[src];
            end
        end
        @(negedge Clk);
        direct        = isDirect;
        addressSelect = sel;
        // Crossbar needs one edge to settle
        @(negedge Clk);
        for (int k = 0; k < 7; k++) begin
            @(negedge Clk);
            for (int m = 0; m < OutPorts; m++) begin
                add[m] = (int'(counts[m]) > k);
            end
        end
        @(negedge Clk);
        add = '0;
    endtask

    task automatic reduceAndRepeat();
        @(negedge Clk);
        finalAdd = 1'b1;
        @(negedge Clk);
        finalAdd = 1'b0;
        waitFinalReady();
        repeat (2) @(negedge Clk);
        finalAdd = 1'b1;
        @(negedge Clk);
        finalAdd = 1'b0;
        repeat (3) @(negedge Clk);
    endtask

    task automatic runScenario(input logic isDirect,
                               input logic [OutPorts-1:0][SelWidth-1:0] sel,
                               input logic [OutPorts-1:0][2:0] counts);
        applyReset();
        startMultipliers();
        routeAndStrobe(isDirect, sel, counts);
        reduceAndRepeat();
    endtask

    initial begin
        Clk           = 1'b0;
        Rst           = 1'b1;
        operands      = '0;
        mStart        = '0;
        addressSelect = '0;
        direct        = 1'b0;
        add           = '0;
        finalAdd      = 1'b0;
        seed          = 32'h1b588225;
        errorCount    = 0;
        timeoutCount  = 0;
        expTotal      = '0;

        // Direct routing, one strobe each
        runScenario(1'b1, {2'd0, 2'd0, 2'd0, 2'd0}, {3'd1, 3'd1, 3'd1, 3'd1});
        // Permutation
        runScenario(1'b0, {2'd2, 2'd1, 2'd3, 2'd0}, {3'd1, 3'd1, 3'd1, 3'd1});
        // Duplicate sources
        runScenario(1'b0, {2'd0, 2'd0, 2'd2, 2'd2}, {3'd1, 3'd1, 3'd1, 3'd1});
        // Repeated and masked strobes
        runScenario(1'b0, {2'd0, 2'd3, 2'd3, 2'd1}, {3'd1, 3'd2, 3'd0, 3'd3});
        runScenario(1'b1, {2'd0, 2'd0, 2'd0, 2'd0}, {3'd4, 3'd1, 3'd2, 3'd0});
        runScenario(1'b0, {2'd1, 2'd2, 2'd3, 2'd0}, {3'd7, 3'd0, 3'd5, 3'd6});

        $display("Checks done: %0d errors, %0d timeouts", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
matAccPkg.sv
seqMultiplier.sv
productCrossbar.sv
productAccumulator.sv
finalReducer.sv
matrixAccelerator.sv
tbMatrixAccelerator.sv

// ==== runSim.sh ====
#!/bin/sh
# Build and run the matrix accelerator testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing \
    -f filelist.f \
    --top-module tbMatrixAccelerator \
    -o simMatrixAccelerator

./obj_dir/simMatrixAccelerator > sim.log 2>&1 || true
cat sim.log

if grep -qx "Simulation completed successfully" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
